//--- irq_fetch.f
verilog/irq_types_pkg.sv
verilog/irq_csr_pkg.sv
verilog/irq_sequencer.sv
verilog/pc_unit.sv
verilog/irq_csr.sv
verilog/irq_fetch_top.sv
tests/irq_fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module irq_fetch_tb -f irq_fetch.f; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Virq_fetch_tb)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

//--- tests/irq_fetch_tb.sv
`timescale 1ns/1ps

module irq_fetch_tb
    import irq_types_pkg::*;
    import irq_csr_pkg::*;
();

    localparam int reset_cycles = 10;
    // per-test budgets: reset, csr, entry, return, redirect, disabled, then margin
    localparam int watchdog_cycles = reset_cycles + 60 + 120 + 150 + 150 + 400 + 110 + 1000;
    localparam opcode_t opc_addi = 7'h13;   // any non-SYSTEM instruction

    logic clk = 1'b0;
    logic nrst;
    logic irq_n, fetch_en, redirect;
    pc_t redirect_pc, pc;
    opcode_t opcode;
    logic fetch_stall, isr_active;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    axi_addr_t awaddr, araddr;
    axi_data_t wdata, rdata;
    axi_strb_t wstrb;
    axi_resp_t bresp, rresp;

    // reference model state
    seq_state_t m_state;
    stall_cnt_t m_cnt;
    logic m_armed, m_sel, m_enable;
    pc_t m_pc, m_saved, m_vector;
    int m_entries;

    integer seed;
    int errors = 0;
    int cmp_errors = 0;
    string test_name = "reset";
    bit gap_mode = 1'b0;          // random fetch_en gaps

    always #5 clk = ~clk;

    irq_fetch_top #(.pc_width(12)) uut (.*);

    // pc priority: vector entry, return restore, redirect, then step when not draining
    function automatic pc_t ref_next_pc(pc_t cur, logic sel, seq_state_t st, stall_cnt_t cnt,
                                        logic fe, logic redir, pc_t target, pc_t vec,
                                        pc_t saved);
        logic draining;
        logic ret;
        draining = (st == seq_enter) || (st == seq_exit);
        ret = (st == seq_exit) && fe && (cnt == exit_drain - 3'd1);
        if (sel)
            return vec;
        else if (ret)
            return saved;
        else if (redir)
            return target;
        else if (fe && !draining)
            return cur + 12'd4;
        return cur;
    endfunction

    always @(posedge clk) begin
        logic accept;
        logic draining;
        logic sel_next;
        pc_t next_pc;
        accept = (m_state == seq_idle) && !irq_n && m_enable && m_armed;
        draining = (m_state == seq_enter) || (m_state == seq_exit);
        sel_next = 1'b0;
        if (!nrst) begin
            m_state = seq_idle;
            m_cnt = '0;
            m_armed = 1'b1;
            m_sel = 1'b0;
            m_pc = '0;
            m_saved = '0;
            m_entries = 0;
        end else begin
            next_pc = ref_next_pc(m_pc, m_sel, m_state, m_cnt, fetch_en, redirect,
                                  redirect_pc, m_vector, m_saved);
            if (accept)
                m_saved = m_pc;            // resume point at acceptance
            else if (draining && redirect)
                m_saved = redirect_pc;
            case (m_state)
                seq_idle: begin
                    if (accept) begin
                        m_state = seq_enter;
                        m_cnt = '0;
                    end
                end
                seq_enter: begin
                    if (fetch_en && m_cnt == enter_drain - 3'd1) begin
                        m_state = seq_running;
                        m_cnt = '0;
                        sel_next = 1'b1;
                        m_entries++;
                    end else if (fetch_en) begin
                        m_cnt = m_cnt + 3'd1;
                    end
                end
                seq_running: begin
                    if (opcode == opc_system) begin
                        m_state = seq_exit;
                        m_cnt = '0;
                    end
                end
                default: begin
                    if (fetch_en && m_cnt == exit_drain - 3'd1) begin
                        m_state = seq_idle;
                        m_cnt = '0;
                    end else if (fetch_en) begin
                        m_cnt = m_cnt + 3'd1;
                    end
                end
            endcase
            if (irq_n)
                m_armed = 1'b1;
            else if (accept)
                m_armed = 1'b0;
            m_sel = sel_next;
            m_pc = next_pc;
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual, inout int count);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
            count++;
        end
    endtask

    // outputs only depend on registers, so they are settled at the falling edge
    always @(negedge clk) begin
        if (nrst) begin
            check_value("pc", 32'(m_pc), 32'(pc), cmp_errors);
            check_value("fetch_stall", 32'(m_state == seq_enter || m_state == seq_exit),
                        32'(fetch_stall), cmp_errors);
            check_value("isr_active", 32'(m_state == seq_running || m_state == seq_exit),
                        32'(isr_active), cmp_errors);
        end
    end

    task automatic next_cycle();
        logic [31:0] rnd;
        @(negedge clk);
        if (gap_mode) begin
            rnd = $random(seed);
            fetch_en = (rnd[1:0] != 2'b00);   // about one cycle in four stalls
        end
    endtask

    task automatic axi_write(input axi_addr_t addr, input axi_data_t data);
        int n;
        n = 0;
        awaddr = addr;
        wdata = data;
        wstrb = 4'hf;
        awvalid = 1'b1;
        wvalid = 1'b1;
        next_cycle();
        while (!(awready && wready) && n < 20) begin
            next_cycle();
            n++;
        end
        next_cycle();                          // handshake edge has passed
        awvalid = 1'b0;
        wvalid = 1'b0;
        if (!bvalid || bresp !== resp_okay) begin
            $display("write to 0x%0h got no okay response", addr);
            errors++;
        end
    endtask

    task automatic axi_read(input axi_addr_t addr, output axi_data_t data,
                            output axi_resp_t resp);
        int n;
        n = 0;
        araddr = addr;
        arvalid = 1'b1;
        next_cycle();
        while (!arready && n < 20) begin
            next_cycle();
            n++;
        end
        next_cycle();
        arvalid = 1'b0;
        if (!rvalid) begin
            $display("read of 0x%0h got no response", addr);
            errors++;
        end
        data = rdata;
        resp = rresp;
    endtask

    task automatic read_check(input axi_addr_t addr, input logic [31:0] expected,
                              input string what);
        axi_data_t data;
        axi_resp_t resp;
        axi_read(addr, data, resp);
        check_value(what, expected, data, errors);
        check_value({what, " resp"}, 32'(resp_okay), 32'(resp), errors);
    endtask

    task automatic wait_isr_active(input logic level);
        int n;
        n = 0;
        while (isr_active !== level && n < 100) begin
            next_cycle();
            n++;
        end
        if (isr_active !== level) begin
            $display("timed out waiting for isr_active to become %0b", level);
            errors++;
        end
    endtask

    initial begin
        axi_data_t data;
        axi_resp_t resp;
        pc_t accept_pc;
        pc_t target;
        logic [31:0] rnd;
        int n;
        seed = 32'h8336_e6c7;
        nrst = 1'b0;
        irq_n = 1'b1;
        opcode = opc_addi;
        fetch_en = 1'b1;
        redirect = 1'b0;
        redirect_pc = '0;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        bready = 1'b1;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b1;
        m_enable = ctrl_reset;
        m_vector = vector_reset[11:0];
        repeat (reset_cycles) next_cycle();
        nrst = 1'b1;
        check_value("pc", 32'd0, 32'(pc), errors);
        check_value("fetch_stall", 32'd0, 32'(fetch_stall), errors);
        check_value("isr_active", 32'd0, 32'(isr_active), errors);
        read_check(reg_ctrl, 32'd1, "ctrl");
        read_check(reg_vector, 32'h100, "vector");
        read_check(reg_count, 32'd0, "count");

        test_name = "csr_access";
        axi_write(reg_vector, 32'h0000_0240);
        m_vector = 12'h240;
        read_check(reg_vector, 32'h240, "vector");
        axi_write(reg_ctrl, 32'd0);
        m_enable = 1'b0;
        read_check(reg_ctrl, 32'd0, "ctrl");
        axi_write(reg_ctrl, 32'd1);
        m_enable = 1'b1;
        read_check(reg_ctrl, 32'd1, "ctrl");
        axi_read(4'h6, data, resp);            // not word aligned
        check_value("unmapped resp", 32'(resp_slverr), 32'(resp), errors);

        test_name = "entry";
        accept_pc = pc;
        irq_n = 1'b0;
        next_cycle();
        check_value("fetch_stall", 32'd1, 32'(fetch_stall), errors);
        n = 0;
        while (pc != m_vector && n < 50) begin
            next_cycle();
            n++;
        end
        check_value("entry latency", 32'd4, 32'(n), errors);
        irq_n = 1'b1;                          // routine clears the source
        read_check(reg_status, {4'd0, accept_pc, 14'd0, 2'b01}, "status");

        test_name = "return";
        opcode = opc_system;
        next_cycle();
        opcode = opc_addi;
        wait_isr_active(1'b0);
        check_value("restored pc", 32'(accept_pc), 32'(pc), errors);
        read_check(reg_count, 32'(m_entries), "count");

        test_name = "redirect_drain";
        gap_mode = 1'b1;
        for (int i = 0; i < 3; i++) begin
            irq_n = 1'b0;
            n = 0;
            while (!fetch_stall && n < 20) begin
                next_cycle();
                n++;
            end
            rnd = $random(seed);
            target = rnd[11:0] & 12'hffc;
            redirect = 1'b1;
            redirect_pc = target;
            next_cycle();
            redirect = 1'b0;
            wait_isr_active(1'b1);
            irq_n = 1'b1;
            read_check(reg_status, {4'd0, target, 14'd0, 2'b01}, "status");
            opcode = opc_system;
            next_cycle();
            opcode = opc_addi;
            wait_isr_active(1'b0);
            check_value("restored pc", 32'(target), 32'(pc), errors);
        end
        read_check(reg_count, 32'(m_entries), "count");
        gap_mode = 1'b0;
        fetch_en = 1'b1;

        test_name = "disabled";
        axi_write(reg_ctrl, 32'd0);
        m_enable = 1'b0;
        accept_pc = pc;
        irq_n = 1'b0;
        repeat (30) next_cycle();
        check_value("pc step", 32'(accept_pc + 12'd120), 32'(pc), errors);
        irq_n = 1'b1;
        next_cycle();

        $display("errors: %0d (sequence %0d, cycle compare %0d)",
                 errors + cmp_errors, errors, cmp_errors);
        if (errors == 0 && cmp_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the test sequence did not finish",
                 watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- verilog/irq_fetch_top.sv
`timescale 1ns/1ps

module irq_fetch_top
    import irq_types_pkg::*;
    import irq_csr_pkg::*;
#(
    parameter int pc_width = 12
) (
    input  logic      clk,
    input  logic      nrst,
    // pipeline side
    input  logic      irq_n,
    input  opcode_t   opcode,
    input  logic      fetch_en,
    input  logic      redirect,
    input  pc_t       redirect_pc,
    output pc_t       pc,
    output logic      fetch_stall,
    output logic      isr_active,
    // AXI4-Lite slave
    input  logic      awvalid,
    output logic      awready,
    input  axi_addr_t awaddr,
    input  logic      wvalid,
    output logic      wready,
    input  axi_data_t wdata,
    input  axi_strb_t wstrb,
    output logic      bvalid,
    input  logic      bready,
    output axi_resp_t bresp,
    input  logic      arvalid,
    output logic      arready,
    input  axi_addr_t araddr,
    output logic      rvalid,
    input  logic      rready,
    output axi_data_t rdata,
    output axi_resp_t rresp
);

    logic irq_enable;
    pc_t  vector;
    pc_t  saved_pc;
    logic sel_isr;
    logic ret_isr;
    logic stall;
    logic isr_running;

    assign fetch_stall = stall;
    assign isr_active  = isr_running;

    irq_sequencer #(.pc_width(pc_width)) u_seq (
        .clk, .nrst,
        .irq_n, .irq_enable, .fetch_en, .redirect,
        .pc, .redirect_pc, .opcode,
        .stall, .sel_isr, .ret_isr, .isr_running, .saved_pc
    );

    pc_unit #(.pc_width(pc_width)) u_pc (
        .clk, .nrst,
        .fetch_en, .redirect, .sel_isr, .ret_isr,
        .redirect_pc, .vector, .saved_pc,
        .stall, .pc
    );

    irq_csr #(.pc_width(pc_width)) u_csr (
        .clk, .nrst,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .isr_running,
        .stalling   (stall),     // status mirrors the fetch stall
        .saved_pc,
        .irq_enable, .vector
    );

endmodule

//--- verilog/irq_csr.sv
`timescale 1ns/1ps

module irq_csr
    import irq_types_pkg::*;
    import irq_csr_pkg::*;
#(
    parameter int pc_width = 12
) (
    input  logic      clk,
    input  logic      nrst,
    // write address and data channels
    input  logic      awvalid,
    output logic      awready,
    input  axi_addr_t awaddr,
    input  logic      wvalid,
    output logic      wready,
    input  axi_data_t wdata,
    input  axi_strb_t wstrb,
    // write response
    output logic      bvalid,
    input  logic      bready,
    output axi_resp_t bresp,
    // read address and data
    input  logic      arvalid,
    output logic      arready,
    input  axi_addr_t araddr,
    output logic      rvalid,
    input  logic      rready,
    output axi_data_t rdata,
    output axi_resp_t rresp,
    // from the sequencer
    input  logic      isr_running,
    input  logic      stalling,
    input  pc_t       saved_pc,
    // to the sequencer and PC unit
    output logic      irq_enable,
    output pc_t       vector
);

    logic                ctrl_en;
    logic [pc_width-1:0] vec_q;
    axi_data_t           entry_cnt;
    logic                running_q;   // for edge detect on isr_running
    logic                wr_fire;
    logic                rd_fire;
    axi_data_t           ctrl_word;
    axi_data_t           vector_word;
    axi_data_t           status_word;
    axi_data_t           rd_word;
    axi_data_t           ctrl_merged;
    axi_data_t           vector_merged;

    function automatic logic addr_mapped(axi_addr_t addr);
        return addr inside {reg_ctrl, reg_vector, reg_status, reg_count};
    endfunction

    // byte lane merge of a write into the current register value
    function automatic axi_data_t apply_strb(axi_data_t old_word, axi_data_t new_word,
                                             axi_strb_t strb);
        axi_data_t merged;
        merged = old_word;
        for (int i = 0; i < $bits(axi_strb_t); i++) begin
            if (strb[i])
                merged[i*8 +: 8] = new_word[i*8 +: 8];
        end
        return merged;
    endfunction

    assign wr_fire = awvalid && awready && wvalid && wready;
    assign rd_fire = arvalid && arready;

    assign irq_enable = ctrl_en;
    assign vector     = vec_q;

    assign ctrl_merged   = apply_strb(ctrl_word, wdata, wstrb);
    assign vector_merged = apply_strb(vector_word, wdata, wstrb);

    always_comb begin
        ctrl_word   = '0;
        vector_word = '0;
        status_word = '0;
        ctrl_word[ctrl_enable_bit]                           = ctrl_en;
        vector_word[pc_width-1:0]                            = vec_q;
        status_word[status_running_bit]                      = isr_running;
        status_word[status_stalling_bit]                     = stalling;
        status_word[status_saved_pc_lsb +: pc_width]         = saved_pc;
        case (araddr)
            reg_ctrl:   rd_word = ctrl_word;
            reg_vector: rd_word = vector_word;
            reg_status: rd_word = status_word;
            reg_count:  rd_word = entry_cnt;
            default:    rd_word = '0;
        endcase
    end

    // write side, address and data accepted together
    always_ff @(posedge clk) begin
        if (!nrst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !awready && !bvalid;
            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire)
            bresp <= addr_mapped(awaddr) ? resp_okay : resp_slverr;
    end

    // read side
    always_ff @(posedge clk) begin
        if (!nrst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= addr_mapped(araddr) ? resp_okay : resp_slverr;
        end
    end

    // registers
    always_ff @(posedge clk) begin
        if (!nrst) begin
            ctrl_en   <= ctrl_reset;
            vec_q     <= vector_reset[pc_width-1:0];
            entry_cnt <= '0;
            running_q <= 1'b0;
        end else begin
            running_q <= isr_running;
            if (wr_fire && awaddr == reg_ctrl)
                ctrl_en <= ctrl_merged[ctrl_enable_bit];
            if (wr_fire && awaddr == reg_vector)
                vec_q <= vector_merged[pc_width-1:0];
            if (wr_fire && awaddr == reg_count)
                entry_cnt <= '0;                     // clear wins over a new entry
            else if (isr_running && !running_q)
                entry_cnt <= entry_cnt + 32'd1;
        end
    end

    // a write is only taken once the last response has gone, one response per write
    a_one_resp_per_write: assert property (@(posedge clk) disable iff (!nrst)
        wr_fire |-> !bvalid);

endmodule

//--- verilog/pc_unit.sv
`timescale 1ns/1ps

module pc_unit
    import irq_types_pkg::*;
#(
    parameter int pc_width = 12
) (
    input  logic clk,
    input  logic nrst,
    input  logic fetch_en,
    input  logic redirect,
    input  logic sel_isr,
    input  logic ret_isr,
    input  pc_t  redirect_pc,
    input  pc_t  vector,
    input  pc_t  saved_pc,
    input  logic stall,
    output pc_t  pc
);

    localparam logic [pc_width-1:0] pc_step = 4; // one 32-bit instruction

    logic [pc_width-1:0] pc_next;
    logic                pc_load;

    // highest priority first
    always_comb begin
        pc_next = pc;
        pc_load = 1'b1;
        if (sel_isr) begin
            pc_next = vector;          // jump to the service routine
        end else if (ret_isr) begin
            pc_next = saved_pc;        // resume interrupted code
        end else if (redirect) begin
            pc_next = redirect_pc;     // branch or jump from later stages
        end else if (fetch_en && !stall) begin
            pc_next = pc + pc_step;
        end else begin
            pc_load = 1'b0;            // hold
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst)
            pc <= '0;
        else if (pc_load)
            pc <= pc_next;
    end

endmodule

//--- verilog/irq_sequencer.sv
`timescale 1ns/1ps

module irq_sequencer
    import irq_types_pkg::*;
#(
    parameter int pc_width = 12
) (
    input  logic    clk,
    input  logic    nrst,
    input  logic    irq_n,       // active low, held until serviced
    input  logic    irq_enable,
    input  logic    fetch_en,
    input  logic    redirect,
    input  pc_t     pc,
    input  pc_t     redirect_pc,
    input  opcode_t opcode,
    output logic    stall,
    output logic    sel_isr,
    output logic    ret_isr,
    output logic    isr_running,
    output pc_t     saved_pc
);

    seq_state_t state;
    stall_cnt_t drain_cnt;
    logic       armed;           // irq_n has been high since the last entry
    logic       accept;
    logic       capture_en;
    logic [pc_width-1:0] capture_pc;

    assign accept = (state == seq_idle) && !irq_n && irq_enable && armed;

    assign stall       = (state == seq_enter) || (state == seq_exit);
    assign isr_running = (state == seq_running) || (state == seq_exit);

    // return strobe fires on the last drain cycle, pc_unit restores on that edge
    assign ret_isr = (state == seq_exit) && fetch_en &&
                     (drain_cnt == exit_drain - 3'd1);

    // a redirect during the drain moves the resume point
    assign capture_en = accept || (stall && redirect);
    assign capture_pc = (stall && redirect) ? redirect_pc : pc;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state     <= seq_idle;
            drain_cnt <= '0;
            sel_isr   <= 1'b0;
            armed     <= 1'b1;
        end else begin
            sel_isr <= 1'b0; // one cycle pulse
            if (irq_n)
                armed <= 1'b1;

            case (state)
                seq_idle: begin
                    if (accept) begin
                        state     <= seq_enter;
                        drain_cnt <= '0;
                        armed     <= 1'b0; // a held line must not re-enter
                    end
                end
                seq_enter: begin
                    if (fetch_en) begin
                        if (drain_cnt == enter_drain - 3'd1) begin
                            state     <= seq_running;
                            drain_cnt <= '0;
                            sel_isr   <= 1'b1;
                        end else begin
                            drain_cnt <= drain_cnt + 3'd1;
                        end
                    end
                end
                seq_running: begin
                    // wait until the vector has been loaded before honoring URET
                    if (opcode == opc_system && !sel_isr) begin
                        state     <= seq_exit;
                        drain_cnt <= '0;
                    end
                end
                seq_exit: begin
                    if (fetch_en) begin
                        if (ret_isr) begin
                            state     <= seq_idle;
                            drain_cnt <= '0;
                        end else begin
                            drain_cnt <= drain_cnt + 3'd1;
                        end
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst)
            saved_pc <= '0;
        else if (capture_en)
            saved_pc <= capture_pc;
    end

    // the PC can only take one of the two ISR loads at a time
    a_sel_ret_excl: assert property (@(posedge clk) disable iff (!nrst)
        !(sel_isr && ret_isr));

    // fetch is held for the whole drain, released only by the jump or the return
    a_stall_in_drain: assert property (@(posedge clk) disable iff (!nrst)
        $fell(stall) |-> (sel_isr || $past(ret_isr)));

endmodule

//--- verilog/irq_csr_pkg.sv
package irq_csr_pkg;

    // AXI4-Lite bus widths
    typedef logic [3:0]  axi_addr_t;  // byte address, 4 words
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;  // one bit per byte lane
    typedef logic [1:0]  axi_resp_t;

    localparam axi_resp_t resp_okay   = 2'b00;
    localparam axi_resp_t resp_slverr = 2'b10;

    // register map
    localparam axi_addr_t reg_ctrl   = 4'h0;
    localparam axi_addr_t reg_vector = 4'h4;
    localparam axi_addr_t reg_status = 4'h8; // read only
    localparam axi_addr_t reg_count  = 4'hC; // read only, any write clears

    // ctrl fields
    localparam int ctrl_enable_bit = 0;
    localparam logic ctrl_reset    = 1'b1; // interrupts enabled out of reset

    // vector reset value, ISR entry PC
    localparam axi_data_t vector_reset = 32'h0000_0100;

    // status fields
    localparam int status_running_bit  = 0;
    localparam int status_stalling_bit = 1;
    localparam int status_saved_pc_lsb = 16; // saved PC sits in 27:16

endpackage

//--- verilog/irq_types_pkg.sv
package irq_types_pkg;

    // one instruction address, byte addressed, word aligned
    typedef logic [11:0] pc_t;

    // major opcode field, instr[6:0]
    typedef logic [6:0] opcode_t;

    // pipeline drain counter
    typedef logic [2:0] stall_cnt_t;

    // SYSTEM major opcode, URET arrives with it
    localparam opcode_t opc_system = 7'h73;

    // cycles of fetch_en to wait before the jump and before the return
    localparam stall_cnt_t enter_drain = 3'd3;
    localparam stall_cnt_t exit_drain  = 3'd2;

    typedef enum logic [1:0] {
        seq_idle,    // waiting for an interrupt
        seq_enter,   // draining before the jump to the vector
        seq_running, // executing the service routine
        seq_exit     // draining before the return
    } seq_state_t;

endpackage
